// ==== src/dbg_bus_pkg.sv ====
package dbg_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and encodings
  //////////////////////////////////////////////////////////////////////

  localparam int DR_W      = 53;  // JTAG data register
  localparam int WORD_W    = 32;  // Bus data word
  localparam int ADDR_W    = 32;
  localparam int CNT_W     = 16;  // Words per burst
  localparam int BIT_CNT_W = 6;

  // Burst opcodes, 32-bit words only
  localparam logic [3:0] OP_BWRITE32 = 4'h3;
  localparam logic [3:0] OP_BREAD32  = 4'h7;

  localparam logic [WORD_W-1:0] CRC32_POLY = 32'hEDB8_8320;  // Reflected 802.3 polynomial
  localparam logic [WORD_W-1:0] CRC_INIT   = '1;

  // One bus request, 65 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
    logic              we;     // 1 write, 0 read
  } bus_req_t;

  typedef enum logic [3:0] {
    IDLE, RBEGIN, RREADY, RSTATUS, RBURST, RCRC,
    WREADY, WWAIT, WBURST, WCRC, WMATCH
  } dbg_state_e;

  // Per-cycle commands from the burst FSM
  typedef struct packed {
    logic       addr_ld;     // Load address and opcode from the command
    logic       addr_inc;    // Step address by one word
    logic       cnt_ld;
    logic       cnt_dec;
    logic       bit_rst;
    logic       bit_en;
    logic       out_ld;      // Parallel load of read word
    logic       out_shift;
    logic       crc_clr;     // Also clears the bus overrun flag
    logic       crc_en;
    logic       crc_in_tdi;  // CRC input from TDI, else from output register
    logic       crc_shift;
    logic       strobe;      // Start one bus access
    logic [1:0] tdo_sel;     // 0 status, 1 data, 2 match, 3 CRC
  } ctrl_t;

  // Data register layout, MSB first
  typedef struct packed {
    logic              top;    // 0 for a module command
    logic [3:0]        op;
    logic [ADDR_W-1:0] addr;
    logic [CNT_W-1:0]  count;
  } cmd_t;

endpackage

// ==== src/dbg_crc32.sv ====
`timescale 1ns/1ps

module dbg_crc32 import dbg_bus_pkg::*; #(
  parameter logic [WORD_W-1:0] CRC_POLY = CRC32_POLY
) (
  input  logic              tck_i,
  input  logic              rst_i,
  input  logic              clr_i,    // Start of burst
  input  logic              en_i,     // Hash one bit
  input  logic              shift_i,  // Send result out
  input  logic              data_i,
  input  logic [WORD_W-1:0] cmp_i,
  output logic              match_o,
  output logic              serial_o
);

  logic [WORD_W-1:0] crc_q;
  logic              fb;

  assign fb = crc_q[0] ^ data_i;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= CRC_INIT;
    end else if (clr_i) begin
      crc_q <= CRC_INIT;
    end else if (en_i) begin
      crc_q <= {1'b0, crc_q[WORD_W-1:1]} ^ (fb ? CRC_POLY : '0);  // LSB-first update
    end else if (shift_i) begin
      crc_q <= {1'b0, crc_q[WORD_W-1:1]};
    end
  end

  assign match_o  = (crc_q == cmp_i);  // No final inversion
  assign serial_o = crc_q[0];

endmodule

// ==== src/dbg_bus_master.sv ====
`timescale 1ns/1ps

module dbg_bus_master import dbg_bus_pkg::*; (
  input  logic              tck_i,
  input  logic              rst_i,
  input  logic              strobe_i,
  input  logic              crc_clr_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [WORD_W-1:0] wdata_i,
  input  logic              rd_op_i,
  input  logic              bus_req_ready_i,
  input  logic              bus_resp_valid_i,
  input  logic [WORD_W-1:0] bus_rdata_i,
  output bus_req_t          bus_req_o,
  output logic              bus_req_valid_o,
  output logic              ready_o,
  output logic [WORD_W-1:0] rdata_o,
  output logic              overrun_o
);

  bus_req_t          req_q;
  logic              valid_q;
  logic              ready_q;    // No access in flight
  logic              overrun_q;  // Sticky for the burst
  logic [WORD_W-1:0] rdata_q;

  // Request payload, only written when idle
  always_ff @(posedge tck_i) begin
    if (strobe_i && ready_q) begin
      req_q <= '{addr: addr_i, wdata: wdata_i, we: ~rd_op_i};
    end
  end

  always_ff @(posedge tck_i) begin
    if (bus_resp_valid_i && !ready_q) rdata_q <= bus_rdata_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q   <= 1'b0;
      ready_q   <= 1'b1;
      overrun_q <= 1'b0;
    end else begin
      if (crc_clr_i) overrun_q <= 1'b0;
      if (strobe_i && ready_q) begin
        valid_q <= 1'b1;
        ready_q <= 1'b0;
      end else if (strobe_i) begin
        overrun_q <= 1'b1;  // Previous access still busy, word dropped
      end
      if (valid_q && bus_req_ready_i) valid_q <= 1'b0;  // Transfer done
      if (bus_resp_valid_i && !ready_q) ready_q <= 1'b1;
    end
  end

  assign bus_req_o       = req_q;
  assign bus_req_valid_o = valid_q;
  assign ready_o         = ready_q;
  assign rdata_o         = rdata_q;
  assign overrun_o       = overrun_q;

endmodule

// ==== src/dbg_datapath.sv ====
`timescale 1ns/1ps

module dbg_datapath import dbg_bus_pkg::*; (
  input  logic              tck_i,
  input  logic              rst_i,
  input  logic              tdi_i,
  input  logic              shift_dr_i,
  input  logic              module_select_i,
  input  ctrl_t             ctrl_i,
  input  logic              biu_ready_i,
  input  logic              crc_match_i,
  input  logic              crc_serial_i,
  input  logic              overrun_i,
  input  logic [WORD_W-1:0] rdata_i,
  output cmd_t              cmd_o,
  output logic              cnt_zero_o,
  output logic              cnt_one_o,
  output logic              bit_max_o,
  output logic [ADDR_W-1:0] addr_o,
  output logic [WORD_W-1:0] wdata_o,
  output logic              rd_op_o,
  output logic              out_bit_o,
  output logic              tdo_o
);

  cmd_t                 dr_q;    // Shift register, TDI enters at MSB
  logic [3:0]           op_q;
  logic [ADDR_W-1:0]    addr_q;
  logic [CNT_W-1:0]     cnt_q;   // Words left
  logic [BIT_CNT_W-1:0] bit_q;
  logic [WORD_W-1:0]    out_q;   // Read word, LSB first

  //////////////////////////////////////////////////////////////////////
  // Data register and command fields
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      dr_q <= '0;
    end else if (module_select_i && shift_dr_i) begin
      dr_q <= cmd_t'({tdi_i, dr_q[DR_W-1:1]});
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      addr_q <= '0;
      op_q   <= '0;
    end else if (ctrl_i.addr_ld) begin
      addr_q <= dr_q.addr;
      op_q   <= dr_q.op;
    end else if (ctrl_i.addr_inc) begin
      addr_q <= addr_q + ADDR_W'(4);  // One 32-bit word
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (ctrl_i.cnt_ld) begin
      cnt_q <= dr_q.count;
    end else if (ctrl_i.cnt_dec) begin
      cnt_q <= cnt_q - CNT_W'(1);
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_q <= '0;
    end else if (ctrl_i.bit_rst) begin
      bit_q <= '0;
    end else if (ctrl_i.bit_en) begin
      bit_q <= bit_q + BIT_CNT_W'(1);
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_q <= '0;  // Keeps TDO low out of reset
    end else if (ctrl_i.out_ld) begin
      out_q <= rdata_i;
    end else if (ctrl_i.out_shift) begin
      out_q <= {1'b0, out_q[WORD_W-1:1]};
    end
  end

  assign cmd_o      = dr_q;
  assign cnt_zero_o = (cnt_q == '0);
  assign cnt_one_o  = (cnt_q == CNT_W'(1));
  assign bit_max_o  = (bit_q == BIT_CNT_W'(WORD_W-1));
  assign addr_o     = addr_q;
  assign rd_op_o    = (op_q == OP_BREAD32);
  assign out_bit_o  = out_q[0];

  // Word is complete with the bit now on TDI
  assign wdata_o = {tdi_i, dr_q[DR_W-1 -: WORD_W-1]};

  // TDO select
  always_comb begin
    case (ctrl_i.tdo_sel)
      2'd0:    tdo_o = biu_ready_i;
      2'd1:    tdo_o = out_q[0];
      2'd2:    tdo_o = crc_match_i & ~overrun_i;  // Lost write fails the burst
      default: tdo_o = crc_serial_i;
    endcase
  end

endmodule

// ==== src/dbg_ctrl_fsm.sv ====
`timescale 1ns/1ps

module dbg_ctrl_fsm import dbg_bus_pkg::*; (
  input  logic  tck_i,
  input  logic  rst_i,
  input  logic  capture_dr_i,
  input  logic  shift_dr_i,
  input  logic  update_dr_i,
  input  logic  module_select_i,
  input  logic  tdi_i,
  input  cmd_t  cmd_i,
  input  logic  cnt_zero_i,
  input  logic  cnt_one_i,
  input  logic  bit_max_i,
  input  logic  biu_ready_i,
  output ctrl_t ctrl_o,
  output logic  top_inhibit_o
);

  dbg_state_e state_q;
  dbg_state_e state_d;
  logic       cmd_ok;    // Valid burst command in the data register
  logic       shifting;  // DR scan active on this module

  assign shifting = module_select_i & shift_dr_i;
  assign cmd_ok   = module_select_i & update_dr_i & ~cmd_i.top &
                    ((cmd_i.op == OP_BREAD32) | (cmd_i.op == OP_BWRITE32));

  // Upper module stays off TDO for the whole data phase
  assign top_inhibit_o = state_q inside {RSTATUS, RBURST, RCRC, WWAIT, WBURST, WCRC, WMATCH};

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state and datapath commands
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    ctrl_o         = '0;
    ctrl_o.tdo_sel = 2'd1;  // Output register by default
    case (state_q)
      IDLE: begin
        if (cmd_ok) begin  // Latch address, count, opcode
          ctrl_o.addr_ld = 1'b1;
          ctrl_o.cnt_ld  = 1'b1;
          ctrl_o.bit_rst = 1'b1;
          ctrl_o.crc_clr = 1'b1;
          state_d = (cmd_i.op == OP_BREAD32) ? RBEGIN : WREADY;
        end
      end
      RBEGIN: begin
        if (cnt_zero_i) begin
          state_d = IDLE;  // Empty burst, nothing to fetch
        end else begin
          ctrl_o.strobe   = 1'b1;  // Fetch first word early
          ctrl_o.addr_inc = 1'b1;
          state_d = RREADY;
        end
      end
      RREADY: begin
        if (module_select_i && capture_dr_i) state_d = RSTATUS;
      end
      RSTATUS: begin
        ctrl_o.tdo_sel = 2'd0;  // Host polls for a 1
        if (shifting && biu_ready_i) begin
          ctrl_o.out_ld  = 1'b1;
          ctrl_o.cnt_dec = 1'b1;
          ctrl_o.bit_rst = 1'b1;
          if (!cnt_one_i) begin  // Prefetch next word
            ctrl_o.strobe   = 1'b1;
            ctrl_o.addr_inc = 1'b1;
          end
          state_d = RBURST;
        end
      end
      RBURST: begin
        if (shifting) begin
          ctrl_o.out_shift = 1'b1;
          ctrl_o.bit_en    = 1'b1;
          ctrl_o.crc_en    = 1'b1;  // Hash the bit now on TDO
          if (bit_max_i) begin
            if (cnt_zero_i) begin
              state_d = RCRC;
            end else begin
              ctrl_o.out_ld  = 1'b1;  // Prefetched word takes over
              ctrl_o.cnt_dec = 1'b1;
              ctrl_o.bit_rst = 1'b1;
              if (!cnt_one_i) begin
                ctrl_o.strobe   = 1'b1;
                ctrl_o.addr_inc = 1'b1;
              end
            end
          end
        end
      end
      RCRC: begin
        ctrl_o.tdo_sel   = 2'd3;
        ctrl_o.crc_shift = shifting;  // Runs until update
      end
      WREADY: begin
        if (cnt_zero_i) begin
          state_d = IDLE;
        end else if (module_select_i && capture_dr_i) begin
          state_d = WWAIT;
        end
      end
      WWAIT: begin
        if (shifting && tdi_i) begin  // Start bit
          ctrl_o.bit_rst = 1'b1;
          state_d = WBURST;
        end
      end
      WBURST: begin
        if (shifting) begin
          ctrl_o.bit_en     = 1'b1;
          ctrl_o.crc_en     = 1'b1;
          ctrl_o.crc_in_tdi = 1'b1;
          if (bit_max_i) begin  // Word complete with TDI
            ctrl_o.strobe   = 1'b1;
            ctrl_o.addr_inc = 1'b1;
            ctrl_o.cnt_dec  = 1'b1;
            ctrl_o.bit_rst  = 1'b1;
            if (cnt_one_i) state_d = WCRC;
          end
        end
      end
      WCRC: begin
        ctrl_o.bit_en = shifting;  // Host CRC enters the data register
        if (shifting && bit_max_i) state_d = WMATCH;
      end
      WMATCH: begin
        ctrl_o.tdo_sel = 2'd2;
      end
      default: state_d = IDLE;
    endcase
    // Early termination from any burst state
    if (state_q != IDLE && update_dr_i) state_d = IDLE;
  end

endmodule

// ==== src/dbg_bus_module.sv ====
`timescale 1ns/1ps

module dbg_bus_module import dbg_bus_pkg::*; (
  input  logic              tck_i,
  input  logic              rst_i,
  input  logic              tdi_i,
  input  logic              capture_dr_i,
  input  logic              shift_dr_i,
  input  logic              update_dr_i,
  input  logic              module_select_i,
  output logic              tdo_o,
  output logic              top_inhibit_o,
  // Bus request channel
  output bus_req_t          bus_req_o,
  output logic              bus_req_valid_o,
  input  logic              bus_req_ready_i,
  // Bus response channel, no back-pressure
  input  logic              bus_resp_valid_i,
  input  logic [WORD_W-1:0] bus_rdata_i
);

  ctrl_t             ctrl;        // FSM commands
  cmd_t              cmd;         // Live data register
  logic              cnt_zero;
  logic              cnt_one;
  logic              bit_max;
  logic              biu_ready;   // Bus master idle, read data valid
  logic              overrun;     // Write arrived before previous response
  logic [WORD_W-1:0] rdata;
  logic [WORD_W-1:0] wdata;
  logic [ADDR_W-1:0] addr;
  logic              rd_op;
  logic              out_bit;     // Output register LSB
  logic              crc_din;
  logic              crc_match;
  logic              crc_serial;

  assign crc_din = ctrl.crc_in_tdi ? tdi_i : out_bit;  // Writes hash TDI, reads hash TDO data

  dbg_ctrl_fsm i_dbg_ctrl_fsm (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .module_select_i (module_select_i),
    .tdi_i           (tdi_i),
    .cmd_i           (cmd),
    .cnt_zero_i      (cnt_zero),
    .cnt_one_i       (cnt_one),
    .bit_max_i       (bit_max),
    .biu_ready_i     (biu_ready),
    .ctrl_o          (ctrl),
    .top_inhibit_o   (top_inhibit_o)
  );

  dbg_datapath i_dbg_datapath (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tdi_i           (tdi_i),
    .shift_dr_i      (shift_dr_i),
    .module_select_i (module_select_i),
    .ctrl_i          (ctrl),
    .biu_ready_i     (biu_ready),
    .crc_match_i     (crc_match),
    .crc_serial_i    (crc_serial),
    .overrun_i       (overrun),
    .rdata_i         (rdata),
    .cmd_o           (cmd),
    .cnt_zero_o      (cnt_zero),
    .cnt_one_o       (cnt_one),
    .bit_max_o       (bit_max),
    .addr_o          (addr),
    .wdata_o         (wdata),
    .rd_op_o         (rd_op),
    .out_bit_o       (out_bit),
    .tdo_o           (tdo_o)
  );

  dbg_crc32 #(
    .CRC_POLY (CRC32_POLY)
  ) i_dbg_crc32 (
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .clr_i    (ctrl.crc_clr),
    .en_i     (ctrl.crc_en),
    .shift_i  (ctrl.crc_shift),
    .data_i   (crc_din),
    .cmp_i    (cmd[DR_W-1 -: WORD_W]),  // Last 32 bits shifted in
    .match_o  (crc_match),
    .serial_o (crc_serial)
  );

  dbg_bus_master i_dbg_bus_master (
    .tck_i            (tck_i),
    .rst_i            (rst_i),
    .strobe_i         (ctrl.strobe),
    .crc_clr_i        (ctrl.crc_clr),
    .addr_i           (addr),
    .wdata_i          (wdata),
    .rd_op_i          (rd_op),
    .bus_req_ready_i  (bus_req_ready_i),
    .bus_resp_valid_i (bus_resp_valid_i),
    .bus_rdata_i      (bus_rdata_i),
    .bus_req_o        (bus_req_o),
    .bus_req_valid_o  (bus_req_valid_o),
    .ready_o          (biu_ready),
    .rdata_o          (rdata),
    .overrun_o        (overrun)
  );

endmodule

// ==== dv/dbg_bus_module_asserts.sv ====
`timescale 1ns/1ps

module dbg_bus_module_asserts import dbg_bus_pkg::*; (
  input logic     tck_i,
  input logic     rst_i,
  input bus_req_t bus_req_o,
  input logic     bus_req_valid_o,
  input logic     bus_req_ready_i
);

  int fail_cnt = 0;  // Failed assertion count

  //////////////////////////////////////////////////////////////////////
  // Request channel rules
  //////////////////////////////////////////////////////////////////////

  // Pending request holds until the transfer edge
  property req_stable_p;
    @(posedge tck_i) disable iff (rst_i)
      (bus_req_valid_o && !bus_req_ready_i) |=> (bus_req_valid_o && $stable(bus_req_o));
  endproperty

  // First cycle out of reset has no request
  property valid_low_after_reset_p;
    @(posedge tck_i) $fell(rst_i) |-> !bus_req_valid_o;
  endproperty

  req_stable_a : assert property (req_stable_p)
    else begin
      $error("bus request changed or dropped before the transfer");
      fail_cnt++;
    end
  valid_low_a : assert property (valid_low_after_reset_p)
    else begin
      $error("bus request valid high right after reset");
      fail_cnt++;
    end

endmodule

bind dbg_bus_master dbg_bus_module_asserts i_dbg_bus_module_asserts (.*);

// ==== dv/dbg_bus_module_tb.sv ====
`timescale 1ns/1ps

module dbg_bus_module_tb import dbg_bus_pkg::*; ();

  logic tck_i, rst_i, tdi_i, capture_dr_i, shift_dr_i, update_dr_i, module_select_i;
  logic tdo_o, top_inhibit_o, bus_req_valid_o, bus_req_ready_i, bus_resp_valid_i;
  logic [WORD_W-1:0] bus_rdata_i;
  bus_req_t bus_req_o;

  integer            seed = 32'hfa39_5ac0;
  logic [31:0]       mem [logic [31:0]];      // Written words only
  logic [31:0]       wr_addr_q[$];
  logic [31:0]       wr_data_q[$];
  logic [31:0]       exp_q[$];                // Compare FIFO
  logic [31:0]       act_q[$];
  string             tag_q[$];
  logic [31:0]       ref_words [0:15];        // Words of current burst
  int                ready_hold = 0;          // Extra cycles before ready
  int                resp_hold  = 0;          // Extra cycles before response
  int                req_count  = 0;
  int                errors = 0, checks = 0, tests = 0, failed = 0, err_start = 0;
  logic              mem_busy = 0;
  logic              inhibit_exp = 0;         // Data phase in progress

  dbg_bus_module i_dbg_bus_module (.*);

  initial begin
    tck_i = 0;
    forever #20 tck_i = ~tck_i;  // 40 ns period
  end

  initial begin
    repeat (100000) @(posedge tck_i);
    $display("ERROR: watchdog expired, simulation stuck");
    $display("FAIL: see errors above");
    $finish;
  end

  // Fill pattern over the whole address
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    if (mem.exists(a)) return mem[a];
    return {a[15:0], ~a[31:16]} ^ 32'h1234_5678;
  endfunction

  // Reference CRC, LSB first, no final inversion
  function automatic logic [31:0] crc_of_words(input int n);
    logic [31:0] c;
    logic        fb;
    c = '1;
    for (int w = 0; w < n; w++) begin
      for (int b = 0; b < 32; b++) begin
        fb = c[0] ^ ref_words[w][b];
        c  = (c >> 1) ^ (fb ? CRC32_POLY : 32'h0);
      end
    end
    return c;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus memory model
  //////////////////////////////////////////////////////////////////////

  initial begin : mem_model
    bus_req_t req;
    int       stall;
    bus_req_ready_i  = 0;
    bus_resp_valid_i = 0;
    bus_rdata_i      = '0;
    forever begin
      @(posedge tck_i);
      #2;
      if (bus_req_valid_o && !rst_i) begin
        mem_busy = 1;
        req      = bus_req_o;
        req_count++;
        stall = $unsigned($random(seed)) % 9;  // 0 to 8 cycles
        repeat (stall + ready_hold) begin
          @(posedge tck_i);
          #2;
        end
        bus_req_ready_i = 1;
        @(posedge tck_i);  // Transfer edge
        #2 bus_req_ready_i = 0;
        if (req.we) begin
          mem[req.addr] = req.wdata;
          wr_addr_q.push_back(req.addr);
          wr_data_q.push_back(req.wdata);
        end
        repeat (resp_hold) @(posedge tck_i);
        #2;
        bus_rdata_i      = req.we ? 32'h0 : mem_word(req.addr);
        bus_resp_valid_i = 1;
        @(posedge tck_i);
        #2 bus_resp_valid_i = 0;
        mem_busy = 0;
      end
    end
  end

  // Compare process, drains the FIFOs every edge
  always @(posedge tck_i) begin
    while (exp_q.size() > 0 && act_q.size() > 0) begin
      checks++;
      assert (act_q[0] === exp_q[0]) else begin
        $display("MISMATCH at %0d ns: %s expected %h got %h", $time, tag_q[0], exp_q[0], act_q[0]);
        errors++;
      end
      void'(exp_q.pop_front());
      void'(act_q.pop_front());
      void'(tag_q.pop_front());
    end
  end

  task automatic push_check(input string tag, input logic [31:0] e, input logic [31:0] a);
    tag_q.push_back(tag);
    exp_q.push_back(e);
    act_q.push_back(a);
  endtask

  //////////////////////////////////////////////////////////////////////
  // JTAG host tasks
  //////////////////////////////////////////////////////////////////////

  task automatic drive_cycle(input logic cap, input logic sh, input logic upd, input logic d);
    @(posedge tck_i);
    #2;
    capture_dr_i = cap;
    shift_dr_i   = sh;
    update_dr_i  = upd;
    tdi_i        = d;
  endtask

  task automatic shift_bit(input logic b, output logic o);
    drive_cycle(0, 1, 0, b);
    @(negedge tck_i);
    o = tdo_o;
    if (inhibit_exp) push_check("top_inhibit in data phase", 1, 32'(top_inhibit_o));
  endtask

  task automatic send_cmd(input logic [3:0] op, input logic [31:0] a, input logic [15:0] n);
    cmd_t c;
    logic o;
    c.top = 0;
    c.op = op;
    c.addr = a;
    c.count = n;
    drive_cycle(1, 0, 0, 0);
    for (int i = 0; i < DR_W; i++) shift_bit(c[i], o);  // LSB first
    drive_cycle(0, 0, 1, 0);
    repeat (2) drive_cycle(0, 0, 0, 0);
  endtask

  task automatic wait_bus_idle();
    int k;
    for (k = 0; k < 200 && (mem_busy || bus_req_valid_o); k++) @(posedge tck_i);
    if (mem_busy || bus_req_valid_o) begin
      $display("ERROR: bus did not go idle in 200 cycles");
      errors++;
    end
  endtask

  task automatic write_burst(input logic [31:0] a, input int n, input bit corrupt,
                             input logic match_exp, input bit check_writes);
    logic [31:0] crc;
    logic        o;
    int          k;
    wr_addr_q.delete();
    wr_data_q.delete();
    for (int i = 0; i < n; i++) ref_words[i] = $random(seed);
    crc = crc_of_words(n);
    if (corrupt) crc[5] = ~crc[5];
    send_cmd(OP_BWRITE32, a, 16'(n));
    drive_cycle(1, 0, 0, 0);
    inhibit_exp = 1;
    shift_bit(1, o);                  // Start bit
    for (int i = 0; i < n; i++)
      for (int b = 0; b < 32; b++) shift_bit(ref_words[i][b], o);
    for (int b = 0; b < 32; b++) shift_bit(crc[b], o);
    drive_cycle(0, 0, 0, 0);
    @(negedge tck_i);
    push_check("write match bit", 32'(match_exp), 32'(tdo_o));
    inhibit_exp = 0;
    drive_cycle(0, 0, 1, 0);
    drive_cycle(0, 0, 0, 0);
    wait_bus_idle();
    if (check_writes) begin
      for (k = 0; k < 100 && wr_addr_q.size() < n; k++) @(posedge tck_i);
      if (wr_addr_q.size() != n) begin
        $display("ERROR: expected %0d bus writes, saw %0d", n, wr_addr_q.size());
        errors++;
      end else begin
        for (int i = 0; i < n; i++) begin
          push_check("write address", a + 4 * i, wr_addr_q[i]);
          push_check("write data", ref_words[i], wr_data_q[i]);
        end
      end
    end
  endtask

  // abort_bits > 0 ends the burst early with an update
  task automatic read_burst(input logic [31:0] a, input int n, input int abort_bits);
    logic [31:0] word;
    logic [31:0] crc;
    logic        o;
    int          k;
    send_cmd(OP_BREAD32, a, 16'(n));
    drive_cycle(1, 0, 0, 0);
    inhibit_exp = 1;
    o = 0;
    for (k = 0; k < 300 && !o; k++) shift_bit(0, o);  // Status poll
    if (!o) begin
      $display("ERROR: read status bit never rose");
      errors++;
    end
    for (int i = 0; i < n && abort_bits == 0; i++) begin
      ref_words[i] = mem_word(a + 4 * i);
      for (int b = 0; b < 32; b++) begin
        shift_bit(0, o);
        word[b] = o;
      end
      push_check("read data", ref_words[i], word);
    end
    if (abort_bits == 0) begin
      for (int b = 0; b < 32; b++) begin
        shift_bit(0, o);
        crc[b] = o;
      end
      push_check("read CRC", crc_of_words(n), crc);
    end else begin
      repeat (abort_bits) shift_bit(0, o);
    end
    inhibit_exp = 0;
    drive_cycle(0, 0, 1, 0);
    drive_cycle(0, 0, 0, 0);
    @(negedge tck_i);
    push_check("top_inhibit after update", 0, 32'(top_inhibit_o));
    wait_bus_idle();
  endtask

  task automatic end_test(input string name);
    int k;
    for (k = 0; k < 20 && exp_q.size() > 0; k++) @(posedge tck_i);
    @(posedge tck_i);
    tests++;
    if (errors != err_start) failed++;
    $display("test %0s: %0s (%0d errors)", name, (errors == err_start) ? "ok" : "FAILED",
             errors - err_start);
    err_start = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int reqs;
    rst_i = 1;
    {tdi_i, capture_dr_i, shift_dr_i, update_dr_i} = '0;
    module_select_i  = 1;
    repeat (5) @(posedge tck_i);
    #2 rst_i = 0;
    @(negedge tck_i);
    push_check("tdo after reset", 0, 32'(tdo_o));
    push_check("top_inhibit after reset", 0, 32'(top_inhibit_o));
    push_check("req valid after reset", 0, 32'(bus_req_valid_o));

    write_burst(32'h0000_1000, 5, 0, 1, 1);
    end_test("write burst 5 words");
    write_burst(32'h0000_2000, 3, 1, 0, 1);
    end_test("write burst bad CRC");
    read_burst(32'h0000_1000, 4, 0);   // Words from the first write burst
    end_test("read burst 4 words");

    reqs = req_count;
    send_cmd(OP_BWRITE32, 32'h0000_3000, 0);
    send_cmd(OP_BREAD32, 32'h0000_3000, 0);
    repeat (10) drive_cycle(0, 0, 0, 0);
    push_check("requests on count zero", reqs, req_count);
    read_burst(32'h0000_4000, 2, 0);
    end_test("count zero commands");

    read_burst(32'h0000_5000, 4, 40);
    repeat (30) drive_cycle(0, 0, 0, 0);
    read_burst(32'h0000_6000, 3, 0);
    end_test("early termination");

    ready_hold = 50;
    read_burst(32'h0000_7000, 1, 0);
    ready_hold = 0;
    resp_hold  = 40;
    write_burst(32'h0000_8000, 3, 0, 0, 0);
    resp_hold  = 0;
    wait_bus_idle();
    end_test("back-pressure");

    errors += i_dbg_bus_module.i_dbg_bus_master.i_dbg_bus_module_asserts.fail_cnt;
    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== list.f ====
src/dbg_bus_pkg.sv
src/dbg_crc32.sv
src/dbg_bus_master.sv
src/dbg_datapath.sv
src/dbg_ctrl_fsm.sv
src/dbg_bus_module.sv
dv/dbg_bus_module_asserts.sv
dv/dbg_bus_module_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dbg_bus_module_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qFx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
